//--- list.f
oadc_pkg.sv
oadc_reg_decode.sv
oadc_timebase.sv
oadc_freq_counter.sv
oadc_adc_trigger.sv
oadc_status_out.sv
openadc_lite.sv
tb_checker.sv
tb_openadc_lite.sv

//--- oadc_adc_trigger.sv
module oadc_adc_trigger
   import oadc_pkg::*;
(
   input  logic                clk_usb,
   input  logic                reset,
   input  adc_sample_t         adc_i,
   input  logic [ADC_BITS-1:0] level_i,
   input  logic                arm_i,
   output logic                armed_o,
   output logic                triggered_o,
   output logic                trigger_adc_o
);

   logic armed_q;
   logic triggered_q;
   logic trig_q;
   logic level_hit;

   // bit 11 of the level picks the direction
   assign level_hit = level_i[ADC_BITS-1] ? (adc_i.data > level_i)
                                          : (adc_i.data < level_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_q     <= 1'b0;
         triggered_q <= 1'b0;
         trig_q      <= 1'b0;
      end else begin
         trig_q <= 1'b0;
         if (arm_i) begin
            armed_q     <= 1'b1;
            triggered_q <= 1'b0;
         end else if (armed_q && adc_i.valid && level_hit) begin
            trig_q      <= 1'b1; // one shot
            armed_q     <= 1'b0;
            triggered_q <= 1'b1;
         end
      end
   end

   assign armed_o       = armed_q;
   assign triggered_o   = triggered_q;
   assign trigger_adc_o = trig_q;

   single_pulse_a: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o)
      else $error("trigger_adc_o held for more than one cycle");

endmodule

//--- oadc_freq_counter.sv
module oadc_freq_counter
   import oadc_pkg::*;
(
   input  logic       clk_usb,
   input  logic       reset,
   input  logic       ext_clk_i,
   input  logic       gate_i,
   input  logic [7:0] limit_i,
   input  logic       monitor_dis_i,
   output freq_stat_t freq_o
);

   logic                 ext_meta;
   logic                 ext_sync;
   logic                 ext_prev;
   logic                 ext_edge;
   logic [FREQ_BITS-1:0] count;
   logic [FREQ_BITS-1:0] diff;
   logic                 over_limit;
   freq_stat_t           stat_q;

   assign ext_edge = ext_sync && !ext_prev;

   // distance between the finished window and the last one
   assign diff = (stat_q.frequency > count) ? stat_q.frequency - count
                                            : count - stat_q.frequency;
   assign over_limit = diff > {{(FREQ_BITS-8){1'b0}}, limit_i};

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta <= 1'b0;
         ext_sync <= 1'b0;
         ext_prev <= 1'b0;
         count    <= '0;
         stat_q   <= '0;
      end else begin
         ext_meta <= ext_clk_i;
         ext_sync <= ext_meta;
         ext_prev <= ext_sync;
         if (gate_i) begin
            stat_q.frequency <= count;
            count <= ext_edge ? FREQ_BITS'(1) : '0; // edge in gate cycle opens next window
         end else begin
            count <= count + FREQ_BITS'(ext_edge);
         end
         if (monitor_dis_i)
            stat_q.change <= 1'b0;
         else if (gate_i && stat_q.frequency != 0 && over_limit)
            stat_q.change <= 1'b1; // sticky until disabled
      end
   end

   assign freq_o = stat_q;

   change_while_disabled_a: assert property (@(posedge clk_usb) disable iff (reset)
      $rose(freq_o.change) |-> !$past(monitor_dis_i))
      else $error("frequency change flag rose with the monitor disabled");

endmodule

//--- oadc_pkg.sv
package oadc_pkg;

   // widths
   localparam int BYTECNT_BITS = 7;
   localparam int ADC_BITS     = 12;
   localparam int FREQ_BITS    = 32;

   // heartbeat shortened so gates show up in simulation
   localparam int TIMER_BITS = 10;
   localparam int GATE_BIT   = 6;  // one gate per 128 cycles
   localparam int FLASH_BIT  = 7;

   // register map
   localparam logic [7:0] ADDR_GAIN        = 8'h00;
   localparam logic [7:0] ADDR_TRIG_LEVEL  = 8'h01; // 2 bytes with bit 11 for fire above
   localparam logic [7:0] ADDR_LED_SEL     = 8'h02;
   localparam logic [7:0] ADDR_ARM         = 8'h03;
   localparam logic [7:0] ADDR_EXTCLK_CTRL = 8'h04; // limit byte then monitor disable
   localparam logic [7:0] ADDR_STATUS      = 8'h05; // read only
   localparam logic [7:0] ADDR_EXTCLK_FREQ = 8'h06; // read only 4 bytes

   // one register access with single cycle strobes
   typedef struct packed {
      logic [7:0]              addr;
      logic [BYTECNT_BITS-1:0] bytecnt;
      logic [7:0]              wdata;
      logic                    write;
      logic                    read;
   } reg_bus_t;

   typedef struct packed {
      logic                valid;
      logic [ADC_BITS-1:0] data;
   } adc_sample_t;

   // writable configuration
   typedef struct packed {
      logic [7:0]          gain;
      logic [ADC_BITS-1:0] trig_level;
      logic [1:0]          led_sel;
      logic [7:0]          extclk_limit;
      logic                monitor_dis;
   } oadc_cfg_t;

   typedef struct packed {
      logic [FREQ_BITS-1:0] frequency;
      logic                 change;
   } freq_stat_t;

endpackage

//--- oadc_reg_decode.sv
module oadc_reg_decode
   import oadc_pkg::*;
(
   input  logic      clk_usb,
   input  logic      reset,
   input  reg_bus_t  reg_i,
   output oadc_cfg_t cfg_o,
   output logic      arm_o
);

   oadc_cfg_t cfg_q;
   logic      arm_q;
   logic      arm_hit;

   // bytes taken by a writable register or 0
   function automatic int unsigned wr_bytes(input logic [7:0] addr);
      int unsigned n;
      case (addr)
         ADDR_GAIN, ADDR_LED_SEL, ADDR_ARM:   n = 1;
         ADDR_TRIG_LEVEL, ADDR_EXTCLK_CTRL:   n = 2;
         default:                             n = 0;
      endcase
      return n;
   endfunction

   assign arm_hit = reg_i.write && (reg_i.addr == ADDR_ARM) && reg_i.wdata[0];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         cfg_q <= '0;
         arm_q <= 1'b0;
      end else begin
         arm_q <= arm_hit;
         if (reg_i.write) begin
            case (reg_i.addr)
               ADDR_GAIN: cfg_q.gain <= reg_i.wdata;
               ADDR_TRIG_LEVEL: begin
                  if (reg_i.bytecnt == 0)
                     cfg_q.trig_level[7:0] <= reg_i.wdata;
                  else if (reg_i.bytecnt == 1)
                     cfg_q.trig_level[ADC_BITS-1:8] <= reg_i.wdata[ADC_BITS-9:0];
               end
               ADDR_LED_SEL: cfg_q.led_sel <= reg_i.wdata[1:0];
               ADDR_EXTCLK_CTRL: begin
                  if (reg_i.bytecnt == 0)
                     cfg_q.extclk_limit <= reg_i.wdata;
                  else if (reg_i.bytecnt == 1)
                     cfg_q.monitor_dis <= reg_i.wdata[0]; // bit 0 of byte 1
               end
               default: ; // read only or unmapped
            endcase
         end
      end
   end

   assign cfg_o = cfg_q;
   assign arm_o = arm_q;

   // a write past the end of a register would be silently dropped
   bytecnt_range_a: assert property (@(posedge clk_usb) disable iff (reset)
      (reg_i.write && wr_bytes(reg_i.addr) != 0) |-> (reg_i.bytecnt < wr_bytes(reg_i.addr)))
      else $error("register write 0x%02h with bytecnt %0d out of range",
                  reg_i.addr, reg_i.bytecnt);

endmodule

//--- oadc_status_out.sv
module oadc_status_out
   import oadc_pkg::*;
(
   input  logic       clk_usb,
   input  logic       reset,
   input  reg_bus_t   reg_i,
   input  oadc_cfg_t  cfg_i,
   input  freq_stat_t freq_i,
   input  logic       armed_i,
   input  logic       triggered_i,
   input  logic [1:0] heartbeat_i,
   input  logic       flash_i,
   output logic       led_armed_o,
   output logic       led_capture_o,
   output logic [7:0] reg_rdata_o,
   output logic       reg_rvalid_o
);

   logic [7:0] status;
   logic [7:0] rd_mux;
   logic [7:0] rdata_q;
   logic       rvalid_q;

   assign status = {5'b0, freq_i.change, triggered_i, armed_i};

   always_comb begin
      if (freq_i.change) begin
         led_armed_o   = flash_i; // frequency alarm overrides led_sel
         led_capture_o = flash_i;
      end else begin
         case (cfg_i.led_sel)
            2'd1:    {led_armed_o, led_capture_o} = heartbeat_i;
            2'd2:    {led_armed_o, led_capture_o} = {flash_i, armed_i};
            2'd3:    {led_armed_o, led_capture_o} = {heartbeat_i[1], freq_i.change};
            default: {led_armed_o, led_capture_o} = {armed_i, triggered_i};
         endcase
      end
   end

   always_comb begin
      rd_mux = 8'h00;
      case (reg_i.addr)
         ADDR_GAIN: if (reg_i.bytecnt == 0) rd_mux = cfg_i.gain;
         ADDR_TRIG_LEVEL: begin
            if (reg_i.bytecnt == 0)
               rd_mux = cfg_i.trig_level[7:0];
            else if (reg_i.bytecnt == 1)
               rd_mux = {{(16-ADC_BITS){1'b0}}, cfg_i.trig_level[ADC_BITS-1:8]};
         end
         ADDR_LED_SEL: rd_mux = {6'b0, cfg_i.led_sel};
         ADDR_EXTCLK_CTRL: begin
            if (reg_i.bytecnt == 0)
               rd_mux = cfg_i.extclk_limit;
            else if (reg_i.bytecnt == 1)
               rd_mux = {7'b0, cfg_i.monitor_dis};
         end
         ADDR_STATUS: rd_mux = status;
         ADDR_EXTCLK_FREQ: begin
            if (reg_i.bytecnt < FREQ_BITS / 8)
               rd_mux = freq_i.frequency[8*reg_i.bytecnt[1:0] +: 8]; // little endian
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         rvalid_q <= 1'b0;
      else
         rvalid_q <= reg_i.read;
   end

   always_ff @(posedge clk_usb) begin
      if (reg_i.read)
         rdata_q <= rd_mux; // sampled in the strobe cycle
   end

   assign reg_rdata_o  = rdata_q;
   assign reg_rvalid_o = rvalid_q;

endmodule

//--- oadc_timebase.sv
module oadc_timebase
   import oadc_pkg::*;
(
   input  logic       clk_usb,
   input  logic       reset,
   input  logic [7:0] gain_i,
   output logic       gate_o,
   output logic       flash_o,
   output logic [1:0] heartbeat_o,
   output logic       amp_gain_o
);

   logic [TIMER_BITS-1:0] heartbeat;
   logic                  gate_bit_q;
   logic                  gate_q;
   logic                  flash_q;
   logic [8:0]            pwm_acc;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         heartbeat  <= '0;
         gate_bit_q <= 1'b0;
         gate_q     <= 1'b0;
         flash_q    <= 1'b0;
         pwm_acc    <= '0;
      end else begin
         heartbeat  <= heartbeat + 1'b1;
         gate_bit_q <= heartbeat[GATE_BIT];
         gate_q     <= heartbeat[GATE_BIT] && !gate_bit_q; // rising edge only
         if (heartbeat[TIMER_BITS-1])
            flash_q <= ~heartbeat[FLASH_BIT];
         // carry out gives gain/256 duty
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_i};
      end
   end

   assign gate_o      = gate_q;
   assign flash_o     = flash_q;
   assign heartbeat_o = heartbeat[TIMER_BITS-1:TIMER_BITS-2];
   assign amp_gain_o  = pwm_acc[8];

endmodule

//--- openadc_lite.sv
module openadc_lite
   import oadc_pkg::*;
(
   input  logic        clk_usb,
   input  logic        reset,
   input  reg_bus_t    reg_i,
   input  adc_sample_t adc_i,
   input  logic        ext_clk_i,
   output logic [7:0]  reg_rdata_o,
   output logic        reg_rvalid_o,
   output logic        trigger_adc_o,
   output logic        amp_gain_o,
   output logic        led_armed_o,
   output logic        led_capture_o
);

   oadc_cfg_t  cfg;
   freq_stat_t freq;
   logic       arm;
   logic       gate;
   logic       flash;
   logic [1:0] heartbeat;
   logic       armed;
   logic       triggered;

   oadc_reg_decode i_reg_decode (
      .clk_usb (clk_usb),
      .reset   (reset),
      .reg_i   (reg_i),
      .cfg_o   (cfg),
      .arm_o   (arm)
   );

   oadc_timebase i_timebase (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .gain_i      (cfg.gain),
      .gate_o      (gate),
      .flash_o     (flash),
      .heartbeat_o (heartbeat),
      .amp_gain_o  (amp_gain_o)
   );

   oadc_freq_counter i_freq_counter (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .ext_clk_i     (ext_clk_i),
      .gate_i        (gate),
      .limit_i       (cfg.extclk_limit),
      .monitor_dis_i (cfg.monitor_dis),
      .freq_o        (freq)
   );

   oadc_adc_trigger i_adc_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .adc_i         (adc_i),
      .level_i       (cfg.trig_level),
      .arm_i         (arm),
      .armed_o       (armed),
      .triggered_o   (triggered),
      .trigger_adc_o (trigger_adc_o)
   );

   oadc_status_out i_status_out (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_i         (reg_i),
      .cfg_i         (cfg),
      .freq_i        (freq),
      .armed_i       (armed),
      .triggered_i   (triggered),
      .heartbeat_i   (heartbeat),
      .flash_i       (flash),
      .led_armed_o   (led_armed_o),
      .led_capture_o (led_capture_o),
      .reg_rdata_o   (reg_rdata_o),
      .reg_rvalid_o  (reg_rvalid_o)
   );

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module tb_openadc_lite -f list.f -o sim_openadc_lite
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_openadc_lite)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1

//--- tb_checker.sv
module tb_checker
   import oadc_pkg::*;
(
   input  logic       clk_usb,
   input  logic       reset,
   input  reg_bus_t   reg_i,
   input  logic [7:0] rdata_i,
   input  logic       rvalid_i,
   input  logic       trigger_i,
   input  logic       amp_gain_i,
   input  logic       led_armed_i,
   input  logic       led_capture_i,
   output int         trig_pulses_o,
   output int         gain_highs_o,
   output int         led_split_o,
   output int         value_errors_o,
   output int         protocol_errors_o
);

   logic read_q;
   int   trig_pulses;
   int   gain_highs;
   int   led_split;
   int   value_errors = 0;
   int   protocol_errors;

   always @(posedge clk_usb) begin
      if (reset) begin
         read_q          <= 1'b0;
         trig_pulses     <= 0;
         gain_highs      <= 0;
         led_split       <= 0;
         protocol_errors <= 0;
      end else begin
         read_q <= reg_i.read;
         if (read_q && !rvalid_i) begin
            $display("read strobe at %0t got no rvalid one cycle later", $time - 20);
            protocol_errors <= protocol_errors + 1;
         end
         if (rvalid_i && !read_q) begin
            $display("rvalid at %0t without a read strobe the cycle before", $time);
            protocol_errors <= protocol_errors + 1;
         end
         if (trigger_i)
            trig_pulses <= trig_pulses + 1;
         if (amp_gain_i)
            gain_highs <= gain_highs + 1;  // pwm high cycles
         if (led_armed_i !== led_capture_i)
            led_split <= led_split + 1;
      end
   end

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
         value_errors++;
      end
   endtask

   // frequency windows may catch one edge more or less
   task automatic approx(input string name, input logic [31:0] exp, input logic [31:0] act,
                         input int tol);
      if (act > exp + tol || act + tol < exp) begin
         $display("[FAIL] %s: expected 0x%0h +/- %0d, actual 0x%0h", name, exp, tol, act);
         value_errors++;
      end
   endtask

   task automatic leds_track_status(input string name, input logic [7:0] status);
      compare({name, " led_armed"}, {31'h0, status[0]}, {31'h0, led_armed_i});
      compare({name, " led_capture"}, {31'h0, status[1]}, {31'h0, led_capture_i});
   endtask

   assign trig_pulses_o     = trig_pulses;
   assign gain_highs_o      = gain_highs;
   assign led_split_o       = led_split;
   assign value_errors_o    = value_errors;
   assign protocol_errors_o = protocol_errors;

endmodule

//--- tb_openadc_lite.sv
module tb_openadc_lite
   import oadc_pkg::*;
();

   typedef enum logic [3:0] {
      k_write, k_read, k_pwm, k_trig, k_no_arm, k_freq, k_change, k_leds
   } kind_e;

   typedef struct packed {
      kind_e                   kind;
      logic [7:0]              addr;
      logic [BYTECNT_BITS-1:0] bytecnt;
      logic [11:0]             data;
      logic [7:0]              period;   // external clock period in clk_usb cycles
      logic [31:0]             expected;
   } test_t;

   logic        clk_usb = 1'b0;
   logic        reset;
   reg_bus_t    bus;
   adc_sample_t adc;
   logic        ext_clk = 1'b0;
   int          ext_cnt = 0;
   int          ext_period;
   logic [7:0]  rdata;
   logic        rvalid;
   logic        trig;
   logic        amp_gain;
   logic        led_armed;
   logic        led_capture;
   int          trig_pulses;
   int          gain_highs;
   int          led_split;
   int          value_errors;
   int          protocol_errors;
   logic        table_ready = 1'b0;
   test_t       tests[$];
   string       names[$];

   always #10 clk_usb = ~clk_usb;

   openadc_lite i_openadc_lite (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_i         (bus),
      .adc_i         (adc),
      .ext_clk_i     (ext_clk),
      .reg_rdata_o   (rdata),
      .reg_rvalid_o  (rvalid),
      .trigger_adc_o (trig),
      .amp_gain_o    (amp_gain),
      .led_armed_o   (led_armed),
      .led_capture_o (led_capture)
   );

   tb_checker i_checker (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .reg_i             (bus),
      .rdata_i           (rdata),
      .rvalid_i          (rvalid),
      .trigger_i         (trig),
      .amp_gain_i        (amp_gain),
      .led_armed_i       (led_armed),
      .led_capture_i     (led_capture),
      .trig_pulses_o     (trig_pulses),
      .gain_highs_o      (gain_highs),
      .led_split_o       (led_split),
      .value_errors_o    (value_errors),
      .protocol_errors_o (protocol_errors)
   );

   // external clock toggles every half period
   always @(posedge clk_usb) begin
      if (ext_cnt >= ext_period / 2 - 1) begin
         ext_cnt <= 0;
         ext_clk <= ~ext_clk;
      end else begin
         ext_cnt <= ext_cnt + 1;
      end
   end

   function automatic void add_test(input string name, input kind_e kind, input logic [7:0] addr,
                                    input logic [BYTECNT_BITS-1:0] bc, input logic [11:0] data,
                                    input logic [7:0] period, input logic [31:0] expected);
      names.push_back(name);
      tests.push_back('{kind: kind, addr: addr, bytecnt: bc, data: data, period: period,
                        expected: expected});
   endfunction

   function automatic void build_table();
      add_test("gain_wr", k_write, ADDR_GAIN, 0, 12'h05a, 8, 0);
      add_test("gain_rd", k_read, ADDR_GAIN, 0, 0, 8, 32'h5a);
      add_test("level_wr0", k_write, ADDR_TRIG_LEVEL, 0, 12'h034, 8, 0);
      add_test("level_wr1", k_write, ADDR_TRIG_LEVEL, 1, 12'h00a, 8, 0);
      add_test("level_rd0", k_read, ADDR_TRIG_LEVEL, 0, 0, 8, 32'h34);
      add_test("level_rd1", k_read, ADDR_TRIG_LEVEL, 1, 0, 8, 32'h0a);
      add_test("led_sel_wr", k_write, ADDR_LED_SEL, 0, 12'h002, 8, 0);
      add_test("led_sel_rd", k_read, ADDR_LED_SEL, 0, 0, 8, 32'h02);
      add_test("limit_wr", k_write, ADDR_EXTCLK_CTRL, 0, 12'h004, 8, 0);
      add_test("mon_dis_wr", k_write, ADDR_EXTCLK_CTRL, 1, 12'h001, 8, 0);
      add_test("limit_rd", k_read, ADDR_EXTCLK_CTRL, 0, 0, 8, 32'h04);
      add_test("mon_dis_rd", k_read, ADDR_EXTCLK_CTRL, 1, 0, 8, 32'h01);
      add_test("unmapped_07", k_read, 8'h07, 0, 0, 8, 0);
      add_test("unmapped_80", k_read, 8'h80, 0, 0, 8, 0);
      add_test("pwm_00", k_pwm, 0, 0, 12'h000, 8, 0);
      add_test("pwm_01", k_pwm, 0, 0, 12'h001, 8, 1);
      add_test("pwm_80", k_pwm, 0, 0, 12'h080, 8, 128);
      add_test("pwm_ff", k_pwm, 0, 0, 12'h0ff, 8, 255);
      add_test("trig_above", k_trig, 0, 0, 12'ha00, 8, 1);
      add_test("above_no_rearm", k_no_arm, 0, 0, 12'ha00, 8, 0);
      add_test("trig_below", k_trig, 0, 0, 12'h300, 8, 1);
      add_test("below_no_rearm", k_no_arm, 0, 0, 12'h300, 8, 0);
      add_test("status_trig", k_read, ADDR_STATUS, 0, 0, 8, 32'h02);
      add_test("freq_p8", k_freq, 0, 0, 0, 8, 128 / 8);
      add_test("freq_p4", k_freq, 0, 0, 0, 4, 128 / 4);
      add_test("mon_en_wr", k_write, ADDR_EXTCLK_CTRL, 1, 12'h000, 4, 0);
      add_test("freq_change", k_change, 0, 0, 0, 8, 1);
      add_test("mon_dis_again", k_write, ADDR_EXTCLK_CTRL, 1, 12'h001, 8, 0);
      add_test("status_cleared", k_read, ADDR_STATUS, 0, 0, 8, 32'h02);
      add_test("led_sel_0", k_write, ADDR_LED_SEL, 0, 12'h000, 8, 0);
      add_test("leds_triggered", k_leds, 0, 0, 0, 8, 32'h02);
      add_test("rearm", k_write, ADDR_ARM, 0, 12'h001, 8, 0);
      add_test("leds_armed", k_leds, 0, 0, 0, 8, 32'h01);
   endfunction

   // random samples that hit or miss the level
   function automatic logic [11:0] hit_sample(input logic [11:0] level);
      int l;
      int r;
      l = level;
      if (level[11])
         r = l + 1 + int'($urandom % (4095 - l));
      else
         r = int'($urandom % l);
      return r[11:0];
   endfunction

   function automatic logic [11:0] miss_sample(input logic [11:0] level);
      int l;
      int r;
      l = level;
      if (level[11])
         r = int'($urandom % (l + 1));
      else
         r = l + int'($urandom % (4096 - l));
      return r[11:0];
   endfunction

   task automatic write_reg(input logic [7:0] addr, input logic [BYTECNT_BITS-1:0] bc,
                            input logic [7:0] data);
      @(posedge clk_usb);
      bus <= '{addr: addr, bytecnt: bc, wdata: data, write: 1'b1, read: 1'b0};
      @(posedge clk_usb);
      bus.write <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [BYTECNT_BITS-1:0] bc,
                           output logic [7:0] data);
      int waited;
      @(posedge clk_usb);
      bus <= '{addr: addr, bytecnt: bc, wdata: 8'h00, write: 1'b0, read: 1'b1};
      @(posedge clk_usb);
      bus.read <= 1'b0;
      data = 8'h00;
      waited = 0;
      while (!rvalid && waited < 4) begin  // bounded wait for rvalid
         @(posedge clk_usb);
         waited++;
      end
      if (rvalid)
         data = rdata;
   endtask

   task automatic drive_sample(input logic valid, input logic [11:0] data);
      @(posedge clk_usb);
      adc <= '{valid: valid, data: data};
   endtask

   task automatic run_test(input string name, input test_t t);
      logic [7:0]  rd;
      logic [31:0] value;
      int          base;
      int          b;
      case (t.kind)
         k_write: write_reg(t.addr, t.bytecnt, t.data[7:0]);
         k_read: begin
            read_reg(t.addr, t.bytecnt, rd);
            i_checker.compare(name, t.expected, {24'h0, rd});
         end
         k_pwm: begin
            write_reg(ADDR_GAIN, 0, t.data[7:0]);
            repeat (4) @(posedge clk_usb);
            base = gain_highs;
            repeat (256) @(posedge clk_usb);
            i_checker.compare(name, t.expected, gain_highs - base);
         end
         k_trig, k_no_arm: begin
            if (t.kind == k_trig) begin
               write_reg(ADDR_TRIG_LEVEL, 0, t.data[7:0]);
               write_reg(ADDR_TRIG_LEVEL, 1, {4'h0, t.data[11:8]});
               write_reg(ADDR_ARM, 0, 8'h01);
               repeat (3) @(posedge clk_usb);
            end
            base = trig_pulses;
            repeat (20) drive_sample(1'b1, miss_sample(t.data));
            drive_sample(1'b0, hit_sample(t.data)); // invalid sample must be ignored
            repeat (6) drive_sample(1'b1, hit_sample(t.data));
            drive_sample(1'b0, 12'h000);
            repeat (3) @(posedge clk_usb);
            i_checker.compare(name, t.expected, trig_pulses - base);
         end
         k_freq: begin
            ext_period <= t.period;
            repeat (400) @(posedge clk_usb);  // three gates so the last window is at the new period
            value = '0;
            for (b = 0; b < 4; b++) begin
               read_reg(ADDR_EXTCLK_FREQ, b[BYTECNT_BITS-1:0], rd);
               value[8*b +: 8] = rd;
            end
            i_checker.approx(name, t.expected, value, 1);
         end
         k_change: begin
            ext_period <= t.period;
            repeat (400) @(posedge clk_usb);
            read_reg(ADDR_STATUS, 0, rd);
            i_checker.compare(name, t.expected, {31'h0, rd[2]});
            base = led_split;
            repeat (64) @(posedge clk_usb);
            i_checker.compare({name, " leds split"}, 0, led_split - base);
         end
         default: begin
            read_reg(ADDR_STATUS, 0, rd);
            i_checker.compare(name, t.expected, {24'h0, rd});
            i_checker.leds_track_status(name, t.expected[7:0]);
         end
      endcase
   endtask

   initial begin
      reset = 1'b1;
      bus = '0;
      adc = '0;
      ext_period = 8;
      void'($urandom(32'he1b1));
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk_usb);
      reset <= 1'b0;
      foreach (tests[i])
         run_test(names[i], tests[i]);
      repeat (4) @(posedge clk_usb);
      $display("tests: %0d, value errors: %0d, protocol errors: %0d",
               tests.size(), value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // watchdog allows 600 cycles per table entry
   initial begin
      wait (table_ready);
      repeat (tests.size() * 600) @(posedge clk_usb);
      $display("timeout: the tests did not finish within %0d cycles", tests.size() * 600);
      $display("Simulation failed");
      $finish;
   end

endmodule
